// File: spi_flash_pkg.sv
package spi_flash_pkg;

    typedef logic [1:0] lane_code_t;

    localparam lane_code_t LANE_SINGLE = 2'b00;
    localparam lane_code_t LANE_DUAL   = 2'b01;
    localparam lane_code_t LANE_QUAD   = 2'b10;

    typedef enum logic [2:0] {
        CMD_ONLY      = 3'b000,
        CMD_ANSWER    = 3'b001,
        CMD_ADDR_READ = 3'b010,  // cmd + addr + dummy + answer
        CMD_DATA      = 3'b011,
        CMD_ADDR_DATA = 3'b100,
        CMD_ADDR      = 3'b101,
        CMD_XIP       = 3'b110,  // addr + dummy + answer
        CMD_RESET     = 3'b111
    } cmd_type_t;

    typedef struct packed {
        lane_code_t commd;
        lane_code_t addr;
        lane_code_t datatx;
        lane_code_t rx;
        lane_code_t alt;         // stored but unused
    } frame_struct_t;

    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] bytes;
    } spi_data_u;

    typedef struct packed {
        logic [7:0]    command;
        logic [31:0]   address;
        spi_data_u     datain;
        logic [1:0]    spimode;  // 01 all dual, 10 all quad
        logic [6:0]    nmisobits;
        logic [6:0]    ndatatxbits;
        logic [4:0]    dummy_cycles;
        frame_struct_t frame;
        logic          addr4_on;
        cmd_type_t     cmd_type;
    } spi_cfg_t;

    typedef struct packed {
        lane_code_t lane;
        logic [9:0] bit_end;     // cumulative tx bits at phase end
    } tx_mark_t;

    typedef struct packed {
        logic [71:0]     str2send;
        tx_mark_t [2:0]  marks;
        logic [7:0]      counterstop;
        lane_code_t      rx_lane;
        logic [6:0]      misoctrstop;
        logic [4:0]      dummy_cycles;
        logic [8:0]      sclk_edges;
    } spi_plan_t;

    function automatic logic [2:0] lanes_of(input lane_code_t lane);
        case (lane)
            LANE_DUAL: return 3'd2;
            LANE_QUAD: return 3'd4;
            default:   return 3'd1;
        endcase
    endfunction

    function automatic logic [7:0] cycles_for(input logic [7:0] nbits, input lane_code_t lane);
        logic [8:0] padded;
        padded = {1'b0, nbits} + {6'd0, lanes_of(lane)} - 9'd1;  // round up
        case (lane)
            LANE_DUAL: return padded[8:1];
            LANE_QUAD: return {1'b0, padded[8:2]};
            default:   return nbits;
        endcase
    endfunction

endpackage

// File: spi_cfg_regs.sv
`timescale 1ns/10ps

module spi_cfg_regs import spi_flash_pkg::*; (
    input  logic        rst,
    input  logic        clk,
    input  logic        wr_en,
    input  logic [2:0]  wr_addr,
    input  logic [31:0] wr_data,
    input  logic        busy,
    output spi_cfg_t    cfg,
    output logic        start,
    output logic        cmd_dropped
);

    localparam logic [2:0] ADDR_CTRL    = 3'd0;
    localparam logic [2:0] ADDR_ADDRESS = 3'd1;
    localparam logic [2:0] ADDR_DATA    = 3'd2;
    localparam logic [2:0] ADDR_FRAME   = 3'd3;
    localparam logic [2:0] ADDR_START   = 3'd4;

    logic start_wr;
    logic launch_hold;  // start sent but engine not busy yet
    logic blocked;

    assign start_wr = wr_en && (wr_addr == ADDR_START);
    assign blocked  = busy || start || launch_hold;

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            cfg <= '0;
        end else if (wr_en) begin
            case (wr_addr)
                ADDR_CTRL: begin
                    cfg.command  <= wr_data[7:0];
                    cfg.cmd_type <= cmd_type_t'(wr_data[10:8]);
                    cfg.spimode  <= wr_data[13:12];
                    cfg.addr4_on <= wr_data[16];
                end
                ADDR_ADDRESS: cfg.address <= wr_data;
                ADDR_DATA:    cfg.datain.word <= wr_data;
                ADDR_FRAME: begin
                    cfg.nmisobits    <= wr_data[6:0];
                    cfg.ndatatxbits  <= wr_data[14:8];
                    cfg.dummy_cycles <= wr_data[20:16];
                    cfg.frame        <= frame_struct_t'(wr_data[31:22]);
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            start       <= 1'b0;
            cmd_dropped <= 1'b0;
            launch_hold <= 1'b0;
        end else begin
            start       <= start_wr && !blocked;
            cmd_dropped <= start_wr && blocked;
            if (start) begin
                launch_hold <= 1'b1;
            end else if (busy) begin
                launch_hold <= 1'b0;   // engine has taken the frame
            end
        end
    end

    a_no_start_busy: assert property (@(posedge rst) disable iff (clk) start |-> !busy)
        else $error("start issued while engine busy");

endmodule

// File: spi_config_decoder.sv
`timescale 1ns/10ps

module spi_config_decoder import spi_flash_pkg::*; (
    input  logic      rst,
    input  logic      clk,
    input  spi_cfg_t  cfg,
    input  logic      start,
    output spi_plan_t plan,
    output logic      plan_valid
);

    // spimode overrides the frame field and field code 11 means single
    function automatic lane_code_t resolve(input logic [1:0] spimode, input lane_code_t field);
        case (spimode)
            2'b01:   return LANE_DUAL;
            2'b10:   return LANE_QUAD;
            default: return (field == LANE_DUAL || field == LANE_QUAD) ? field : LANE_SINGLE;
        endcase
    endfunction

    lane_code_t  cmd_lane;
    lane_code_t  addr_lane;
    lane_code_t  data_lane;
    lane_code_t  rx_lane;
    logic [7:0]  addr_bits;
    logic [8:0]  c_cmd;
    logic [8:0]  c_addr;
    logic [8:0]  c_data;
    logic [8:0]  c_rx;
    logic [8:0]  c_dummy;
    logic [8:0]  total_cyc;
    logic [9:0]  end_addr;
    logic [31:0] data_rev;
    logic [71:0] str_full;
    tx_mark_t    m_cmd;
    tx_mark_t    m_addr;
    tx_mark_t    m_cmd_data;
    tx_mark_t    m_addr_data;
    tx_mark_t    m_xip;
    tx_mark_t    m_rst;
    spi_plan_t   plan_d;

    assign cmd_lane  = resolve(cfg.spimode, cfg.frame.commd);
    assign addr_lane = resolve(cfg.spimode, cfg.frame.addr);
    assign data_lane = resolve(cfg.spimode, cfg.frame.datatx);
    assign rx_lane   = resolve(cfg.spimode, cfg.frame.rx);

    assign addr_bits = cfg.addr4_on ? 8'd32 : 8'd24;

    assign c_cmd   = {1'b0, cycles_for(8'd8, cmd_lane)};
    assign c_addr  = {1'b0, cycles_for(addr_bits, addr_lane)};
    assign c_data  = {1'b0, cycles_for({1'b0, cfg.ndatatxbits}, data_lane)};
    assign c_rx    = {1'b0, cycles_for({1'b0, cfg.nmisobits}, rx_lane)};
    assign c_dummy = {4'd0, cfg.dummy_cycles};

    // byte 0 goes out first
    assign data_rev = {cfg.datain.bytes[0], cfg.datain.bytes[1],
                       cfg.datain.bytes[2], cfg.datain.bytes[3]};

    assign str_full = cfg.addr4_on ? {cfg.command, cfg.address, data_rev}
                                   : {cfg.command, cfg.address[23:0], data_rev, 8'h00};

    assign end_addr    = 10'd8 + {2'b00, addr_bits};
    assign m_cmd       = {cmd_lane, 10'd8};
    assign m_addr      = {addr_lane, end_addr};
    assign m_cmd_data  = {data_lane, 10'd8 + {3'b000, cfg.ndatatxbits}};
    assign m_addr_data = {data_lane, end_addr + {3'b000, cfg.ndatatxbits}};
    assign m_xip       = {addr_lane, {2'b00, addr_bits}};
    assign m_rst       = {data_lane, {3'b000, cfg.ndatatxbits}};

    always_comb begin
        plan_d          = '0;
        plan_d.str2send = str_full;
        plan_d.rx_lane  = rx_lane;
        total_cyc       = c_cmd;
        case (cfg.cmd_type)
            CMD_ONLY: begin
                plan_d.counterstop = 8'd8;
                plan_d.marks       = {m_cmd, m_cmd, m_cmd};
            end
            CMD_ANSWER: begin
                plan_d.counterstop = 8'd8;
                plan_d.misoctrstop = cfg.nmisobits;
                plan_d.marks       = {m_cmd, m_cmd, m_cmd};
                total_cyc          = c_cmd + c_rx;
            end
            CMD_ADDR_READ: begin
                plan_d.counterstop  = 8'd8 + addr_bits;
                plan_d.misoctrstop  = cfg.nmisobits;
                plan_d.dummy_cycles = cfg.dummy_cycles;
                plan_d.marks        = {m_addr, m_addr, m_cmd};
                total_cyc           = c_cmd + c_addr + c_dummy + c_rx;
            end
            CMD_DATA: begin
                plan_d.str2send    = {cfg.command, data_rev, 32'h0};
                plan_d.counterstop = 8'd8 + {1'b0, cfg.ndatatxbits};
                plan_d.marks       = {m_cmd_data, m_cmd_data, m_cmd};
                total_cyc          = c_cmd + c_data;
            end
            CMD_ADDR_DATA: begin
                plan_d.counterstop = 8'd8 + addr_bits + {1'b0, cfg.ndatatxbits};
                plan_d.marks       = {m_addr_data, m_addr, m_cmd};
                total_cyc          = c_cmd + c_addr + c_data;
            end
            CMD_ADDR: begin
                plan_d.counterstop = 8'd8 + addr_bits;
                plan_d.marks       = {m_addr, m_addr, m_cmd};
                total_cyc          = c_cmd + c_addr;
            end
            CMD_XIP: begin
                plan_d.str2send     = cfg.addr4_on ? {cfg.address, 40'h0}
                                                   : {cfg.address[23:0], 48'h0};
                plan_d.counterstop  = addr_bits;
                plan_d.misoctrstop  = cfg.nmisobits;
                plan_d.dummy_cycles = cfg.dummy_cycles;
                plan_d.marks        = {m_xip, m_xip, m_xip};
                total_cyc           = c_addr + c_dummy + c_rx;
            end
            default: begin  // reset sequence
                plan_d.str2send    = {data_rev, 40'h0};
                plan_d.counterstop = {1'b0, cfg.ndatatxbits};
                plan_d.marks       = {m_rst, m_rst, m_rst};
                total_cyc          = c_data;
            end
        endcase
        plan_d.sclk_edges = {total_cyc[7:0], 1'b0};
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            plan_valid <= 1'b0;
        end else begin
            plan_valid <= start;
        end
    end

    always_ff @(posedge rst) begin
        if (start) begin
            plan <= plan_d;
        end
    end

    a_edges_even: assert property (@(posedge rst) disable iff (clk)
        plan_valid |-> (plan.sclk_edges != 9'd0) && !plan.sclk_edges[0])
        else $error("frame plan with bad sclk edge count");

endmodule

// File: spi_frame_engine.sv
`timescale 1ns/10ps

module spi_frame_engine import spi_flash_pkg::*; #(
    parameter int CLK_DIV = 2
) (
    input  logic        rst,
    input  logic        clk,
    input  spi_plan_t   plan,
    input  logic        plan_valid,
    input  logic [3:0]  io_in,
    output logic        sclk,
    output logic        cs_n,
    output logic [3:0]  io_out,
    output logic [3:0]  io_oe,
    output logic        busy,
    output logic        done,
    output logic [63:0] rx_data
);

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    typedef enum logic [1:0] {S_IDLE, S_SHIFT, S_FINISH} state_t;

    state_t           state;
    logic [DIV_W-1:0] div_cnt;
    logic             half_tick;
    logic [8:0]       edge_cnt;
    logic [7:0]       tx_cnt;
    logic [6:0]       rx_cnt;
    logic [4:0]       dummy_left;
    logic [71:0]      tx_sr;
    lane_code_t       cur_lane;
    logic [2:0]       tx_step;
    logic [2:0]       rx_lanes;
    logic [2:0]       rx_step;
    logic [6:0]       rx_left;
    logic [3:0]       lane_mask;
    logic [3:0]       tx_bits;
    logic [3:0]       rx_grp;
    logic             tx_active;
    logic             tx_shift;
    logic             dummy_tick;
    logic             rx_sample;

    assign half_tick = (div_cnt == DIV_W'(CLK_DIV - 1));

    // current phase is the first mark not yet reached
    always_comb begin
        if ({2'b00, tx_cnt} < plan.marks[0].bit_end) begin
            cur_lane = plan.marks[0].lane;
        end else if ({2'b00, tx_cnt} < plan.marks[1].bit_end) begin
            cur_lane = plan.marks[1].lane;
        end else begin
            cur_lane = plan.marks[2].lane;
        end
    end

    always_comb begin
        case (cur_lane)
            LANE_QUAD: begin
                lane_mask = 4'b1111;
                tx_bits   = tx_sr[71:68];
            end
            LANE_DUAL: begin
                lane_mask = 4'b0011;
                tx_bits   = {2'b00, tx_sr[71:70]};
            end
            default: begin
                lane_mask = 4'b0001;     // mosi on io0
                tx_bits   = {3'b000, tx_sr[71]};
            end
        endcase
    end

    always_comb begin
        case (plan.rx_lane)
            LANE_QUAD: rx_grp = io_in;
            LANE_DUAL: rx_grp = {io_in[1:0], 2'b00};
            default:   rx_grp = {io_in[1], 3'b000};  // miso on io1
        endcase
    end

    assign tx_step   = lanes_of(cur_lane);
    assign tx_active = (tx_cnt < plan.counterstop);
    assign io_oe     = (state == S_SHIFT && tx_active) ? lane_mask : 4'b0000;
    assign io_out    = tx_bits & io_oe;

    assign rx_lanes = lanes_of(plan.rx_lane);
    assign rx_left  = plan.misoctrstop - rx_cnt;
    assign rx_step  = (rx_left < {4'd0, rx_lanes}) ? rx_left[2:0] : rx_lanes;  // trim last

    assign tx_shift   = (state == S_SHIFT) && half_tick && sclk && tx_active;
    assign dummy_tick = (state == S_SHIFT) && half_tick && !sclk && !tx_active
                        && (dummy_left != 5'd0);
    assign rx_sample  = (state == S_SHIFT) && half_tick && !sclk && !tx_active
                        && (dummy_left == 5'd0) && (rx_cnt < plan.misoctrstop);

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            state      <= S_IDLE;
            div_cnt    <= '0;
            edge_cnt   <= 9'd0;
            tx_cnt     <= 8'd0;
            rx_cnt     <= 7'd0;
            dummy_left <= 5'd0;
            sclk       <= 1'b0;
            cs_n       <= 1'b1;
            busy       <= 1'b0;
            done       <= 1'b0;
        end else begin
            done <= 1'b0;
            if (state == S_IDLE) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
            end
            if (tx_shift) begin
                tx_cnt <= tx_cnt + {5'd0, tx_step};
            end
            if (dummy_tick) begin
                dummy_left <= dummy_left - 5'd1;
            end
            if (rx_sample) begin
                rx_cnt <= rx_cnt + {4'd0, rx_step};
            end
            case (state)
                S_IDLE: begin
                    if (plan_valid) begin
                        state      <= S_SHIFT;
                        busy       <= 1'b1;
                        cs_n       <= 1'b0;
                        edge_cnt   <= 9'd0;
                        tx_cnt     <= 8'd0;
                        rx_cnt     <= 7'd0;
                        dummy_left <= plan.dummy_cycles;
                    end
                end
                S_SHIFT: begin
                    if (half_tick) begin
                        sclk     <= ~sclk;
                        edge_cnt <= edge_cnt + 9'd1;
                        if (edge_cnt == plan.sclk_edges - 9'd1) begin
                            state <= S_FINISH;
                        end
                    end
                end
                default: begin  // hold cs_n for one half period
                    if (half_tick) begin
                        state <= S_IDLE;
                        cs_n  <= 1'b1;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge rst) begin
        if (state == S_IDLE && plan_valid) begin
            tx_sr   <= plan.str2send;
            rx_data <= '0;
        end else begin
            if (tx_shift) begin
                tx_sr <= tx_sr << tx_step;
            end
            if (rx_sample) begin
                case (rx_step)
                    3'd1:    rx_data <= {rx_data[62:0], rx_grp[3]};
                    3'd2:    rx_data <= {rx_data[61:0], rx_grp[3:2]};
                    3'd3:    rx_data <= {rx_data[60:0], rx_grp[3:1]};
                    default: rx_data <= {rx_data[59:0], rx_grp};
                endcase
            end
        end
    end

    a_sclk_in_frame: assert property (@(posedge rst) disable iff (clk) sclk |-> !cs_n)
        else $error("sclk high outside chip select");

endmodule

// File: spi_flash_master.sv
`timescale 1ns/10ps

module spi_flash_master import spi_flash_pkg::*; #(
    parameter int CLK_DIV = 2
) (
    input  logic        rst,
    input  logic        clk,
    input  logic        wr_en,
    input  logic [2:0]  wr_addr,
    input  logic [31:0] wr_data,
    input  logic [3:0]  io_in,
    output logic        sclk,
    output logic        cs_n,
    output logic [3:0]  io_out,
    output logic [3:0]  io_oe,
    output logic        busy,
    output logic        done,
    output logic [63:0] rx_data,
    output logic        cmd_dropped
);

    spi_cfg_t  cfg;
    spi_plan_t plan;
    logic      start;
    logic      plan_valid;

    spi_cfg_regs i_regs (
        .rst         (rst),
        .clk         (clk),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .busy        (busy),
        .cfg         (cfg),
        .start       (start),
        .cmd_dropped (cmd_dropped)
    );

    spi_config_decoder i_decoder (
        .rst        (rst),
        .clk        (clk),
        .cfg        (cfg),
        .start      (start),
        .plan       (plan),
        .plan_valid (plan_valid)
    );

    spi_frame_engine #(
        .CLK_DIV (CLK_DIV)
    ) i_engine (
        .rst        (rst),
        .clk        (clk),
        .plan       (plan),
        .plan_valid (plan_valid),
        .io_in      (io_in),
        .sclk       (sclk),
        .cs_n       (cs_n),
        .io_out     (io_out),
        .io_oe      (io_oe),
        .busy       (busy),
        .done       (done),
        .rx_data    (rx_data)
    );

endmodule

// File: tb_spi_flash_master.sv
`timescale 1ns/10ps

module tb_spi_flash_master;

    localparam int CLK_DIV = 2;
    localparam int MAXL    = 32;

    logic        rst;
    logic        clk;
    logic        wr_en;
    logic [2:0]  wr_addr;
    logic [31:0] wr_data;
    logic [3:0]  io_in;
    logic        sclk;
    logic        cs_n;
    logic [3:0]  io_out;
    logic [3:0]  io_oe;
    logic        busy;
    logic        done;
    logic [63:0] rx_data;
    logic        cmd_dropped;

    logic [31:0] w0_q[MAXL];
    logic [31:0] w1_q[MAXL];
    logic [31:0] w2_q[MAXL];
    logic [31:0] w3_q[MAXL];
    logic [63:0] ans_q[MAXL];
    logic [71:0] tx_q[MAXL];
    int          txn_q[MAXL];
    logic [63:0] rx_q[MAXL];
    int          rises_q[MAXL];
    int          nlines;

    logic [71:0] cap;      // bits seen by the flash
    int          cap_n;
    int          rises;
    int          idle_rises;
    int          dummy_exp;
    int          rx_lanes;
    logic [63:0] ans_sr;
    logic [31:0] rng;
    int          done_cnt;
    int          drop_cnt;
    longint      limit_ns;

    spi_flash_master #(
        .CLK_DIV (CLK_DIV)
    ) i_dut (
        .rst         (rst),
        .clk         (clk),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .io_in       (io_in),
        .sclk        (sclk),
        .cs_n        (cs_n),
        .io_out      (io_out),
        .io_oe       (io_oe),
        .busy        (busy),
        .done        (done),
        .rx_data     (rx_data),
        .cmd_dropped (cmd_dropped)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // bits per clock of the answer phase
    function automatic int lane_count(input logic [31:0] w0, input logic [31:0] w3);
        if (w0[13:12] == 2'b01) return 2;
        if (w0[13:12] == 2'b10) return 4;
        if (w3[25:24] == 2'b01) return 2;
        if (w3[25:24] == 2'b10) return 4;
        return 1;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic write_reg(input logic [2:0] a, input logic [31:0] d);
        wr_en   = 1'b1;
        wr_addr = a;
        wr_data = d;
        @(posedge rst);
        #2;
        wr_en = 1'b0;
    endtask

    task automatic wait_done();
        do @(negedge rst); while (!done);
        @(posedge rst);
        #2;
    endtask

    initial begin
        rst = 1'b0;
        forever #20 rst = ~rst;
    end

    always @(posedge sclk) begin
        rises = rises + 1;
        case (io_oe)
            4'b0000: idle_rises = idle_rises + 1;
            4'b0001: begin
                cap[71 - cap_n] = io_out[0];
                cap_n = cap_n + 1;
            end
            4'b0011: begin
                cap[71 - cap_n]     = io_out[1];
                cap[71 - cap_n - 1] = io_out[0];
                cap_n = cap_n + 2;
            end
            4'b1111: begin
                cap[71 - cap_n -: 4] = io_out;
                cap_n = cap_n + 4;
            end
            default: report_failure($sformatf("ERROR io_oe illegal lane mask 0x%h", io_oe));
        endcase
    end

    // flash answer with random noise on unused lanes
    always @(negedge sclk) begin
        logic [3:0] fill;
        #2;
        rng  = xorshift(rng);
        fill = rng[3:0];
        if (!cs_n && io_oe == 4'b0000 && idle_rises >= dummy_exp) begin
            case (rx_lanes)
                1: begin
                    fill[1] = ans_sr[63];
                    ans_sr  = ans_sr << 1;
                end
                2: begin
                    fill[1:0] = ans_sr[63:62];
                    ans_sr    = ans_sr << 2;
                end
                default: begin
                    fill   = ans_sr[63:60];
                    ans_sr = ans_sr << 4;
                end
            endcase
        end
        io_in = fill;
    end

    always @(negedge rst) begin
        if (done) done_cnt = done_cnt + 1;
        if (cmd_dropped) drop_cnt = drop_cnt + 1;
    end

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        report_failure("simulation timed out waiting for done");
    end

    initial begin
        int    fd;
        int    n;
        string line;
        longint edges;

        clk      = 1'b1;
        wr_en    = 1'b0;
        wr_addr  = 3'd0;
        wr_data  = 32'd0;
        io_in    = 4'd0;
        rng      = 32'he75a6803;
        done_cnt = 0;
        drop_cnt = 0;
        nlines   = 0;
        edges    = 0;

        fd = $fopen("spi_flash_stim.txt", "r");
        if (fd == 0) report_failure("cannot open spi_flash_stim.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 8 || line[0] == 8'h23) continue;   // skip comments
            n = $sscanf(line, "%h %h %h %h %h %h %d %h %d", w0_q[nlines], w1_q[nlines],
                        w2_q[nlines], w3_q[nlines], ans_q[nlines], tx_q[nlines],
                        txn_q[nlines], rx_q[nlines], rises_q[nlines]);
            if (n != 9) report_failure("malformed line in stimulus file");
            edges  = edges + 2 * rises_q[nlines];
            nlines = nlines + 1;
        end
        $fclose(fd);
        edges    = edges + 2 * rises_q[nlines - 1];   // extra frame for the drop test
        limit_ns = edges * CLK_DIV * 40 + (nlines + 1) * 200 * 40 + 16 * 40;

        repeat (16) @(posedge rst);
        #2;
        clk = 1'b0;
        @(negedge rst);
        assert (cs_n === 1'b1 && sclk === 1'b0 && busy === 1'b0 && done === 1'b0
                && io_oe === 4'h0)
        else report_failure($sformatf(
            "ERROR cs_n/sclk/busy/done/io_oe after reset 0x%h/%h/%h/%h/%h exp 0x1/0/0/0/0",
            cs_n, sclk, busy, done, io_oe));
        @(posedge rst);
        #2;

        for (int i = 0; i < nlines; i++) begin
            cap        = '0;
            cap_n      = 0;
            rises      = 0;
            idle_rises = 0;
            dummy_exp  = int'(w3_q[i][20:16]);
            rx_lanes   = lane_count(w0_q[i], w3_q[i]);
            ans_sr     = ans_q[i];
            write_reg(3'd0, w0_q[i]);
            write_reg(3'd1, w1_q[i]);
            write_reg(3'd2, w2_q[i]);
            write_reg(3'd3, w3_q[i]);
            write_reg(3'd4, 32'd0);
            wait_done();
            assert (cap_n == txn_q[i] && cap == tx_q[i])
            else report_failure($sformatf("ERROR tx stream line %0d got 0x%h/%0d exp 0x%h/%0d",
                                          i, cap, cap_n, tx_q[i], txn_q[i]));
            assert (rx_data == rx_q[i])
            else report_failure($sformatf("ERROR rx_data line %0d got 0x%h exp 0x%h",
                                          i, rx_data, rx_q[i]));
            assert (rises == rises_q[i])
            else report_failure($sformatf("ERROR sclk rises line %0d got 0x%h exp 0x%h",
                                          i, rises, rises_q[i]));
        end

        // second start while the frame runs must be dropped
        write_reg(3'd4, 32'd0);
        do @(negedge rst); while (!busy);
        @(posedge rst);
        #2;
        write_reg(3'd4, 32'd0);
        wait_done();
        repeat (4) @(posedge rst);
        #2;
        assert (drop_cnt == 1)
        else report_failure($sformatf("ERROR cmd_dropped pulses got 0x%h exp 0x1", drop_cnt));
        assert (done_cnt == nlines + 1)
        else report_failure($sformatf("ERROR done pulses got 0x%h exp 0x%h",
                                      done_cnt, nlines + 1));

        $display("Done: no errors");
        $finish;
    end

endmodule

// File: spi_flash_master.f
spi_flash_pkg.sv
spi_cfg_regs.sv
spi_config_decoder.sv
spi_frame_engine.sv
spi_flash_master.sv
tb_spi_flash_master.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f spi_flash_master.f \
    --top-module tb_spi_flash_master -o sim_tb &&
./obj_dir/sim_tb ||
{ echo "simulation failed"; exit 1; }

// File: spi_flash_stim.txt
# w0 w1 w2 w3 answer(64) tx_expected(72, msb first) tx_bits rx_expected(64) sclk_rises
# w0 cmd/type/spimode/addr4, w1 address, w2 datain, w3 nmiso/ndatatx/dummy/frame
00000006 00000000 00000000 00000000 0000000000000000 060000000000000000 8 0000000000000000 8
00000520 00123456 00000000 00000000 0000000000000000 201234560000000000 32 0000000000000000 32
00010521 a1b2c3d4 00000000 00000000 0000000000000000 21a1b2c3d400000000 40 0000000000000000 40
00000432 00abcdef 11223344 18002000 0000000000000000 32abcdef4433221100 64 0000000000000000 28
00012438 01020304 deadbeef 00001000 0000000000000000 3801020304efbe0000 56 0000000000000000 14
00000302 00000000 0a0b0c0d 00001800 0000000000000000 020d0c0b0000000000 32 0000000000000000 32
000017ff 00000000 00006699 00001000 0000000000000000 996600000000000000 16 0000000000000000 8
0000019f 00000000 00000000 00000018 ef4018a5a5a5a5a5 9f0000000000000000 8 0000000000ef4018 32
0000026b 00000100 00000000 02080020 0123456789abcdef 6b0001000000000000 32 0000000001234567 48
00011600 00c0ffee 00000000 00040010 beef000000000000 00c0ffee0000000000 32 000000000000beef 28
00000105 00000000 00000000 0200000a abc0000000000000 050000000000000000 8 00000000000002af 11
